// ==== hdl/sched_pkg.sv ====
/*
  Memory scheduler package
  Widths, the column step and the loop-bound types shared by the
  scheduler blocks
*/
`default_nettype none

package sched_pkg;

  // Address and stride width in bits
  localparam int unsigned ADDR_W = 32;
  // Iteration counter width
  localparam int unsigned ITER_W = 16;

  // Datapath and memory word widths in bits
  localparam int unsigned DATA_W = 256;
  localparam int unsigned MEM_DW = 32;

  // Bytes advanced per X column tile and per W column group
  localparam int unsigned COL_JUMP = (MEM_DW / 8) * (DATA_W / MEM_DW);

  // Address or stride
  typedef logic [ADDR_W-1:0] addr_t;

  // Loop count
  typedef logic [ITER_W-1:0] iter_t;

  // Leftover rows on the last X row tile
  typedef logic [7:0] len_t;

endpackage : sched_pkg

`default_nettype wire

// ==== hdl/loop_cfg_if.sv ====
/*
  Loop configuration interface
  Carries the job's loop bounds to the X tile walker and the descriptor latch
*/
`timescale 1ns/100ps
`default_nettype none

interface loop_cfg_if;
  import sched_pkg::*;

  iter_t x_col_iters;
  iter_t x_row_iters;
  iter_t w_col_iters;
  iter_t tot_x_reads;
  len_t  x_leftover;

  modport src (
    output x_col_iters, x_row_iters, w_col_iters, tot_x_reads, x_leftover
  );

  modport walker (
    input x_col_iters, x_row_iters, w_col_iters, tot_x_reads, x_leftover
  );

  // The latch only needs the W column group count
  modport desc (
    input w_col_iters
  );

endinterface : loop_cfg_if

`default_nettype wire

// ==== hdl/x_tile_walker.sv ====
/*
  X tile walker
  Walks the X input tile by tile with column, W column group and row counters
  and forms the X base address, the read count and the reads-open status
*/
`timescale 1ns/100ps
`default_nettype none

module x_tile_walker #(
  parameter int unsigned ARRAY_W = 12,
  parameter int unsigned LEN_W   = $clog2(ARRAY_W) + 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             sched_rst_i,
  input  logic             x_done_i,
  loop_cfg_if.walker       cfg,
  input  sched_pkg::addr_t x_addr_i,
  input  sched_pkg::addr_t x_rows_offs_i,
  output sched_pkg::addr_t x_base_addr_o,
  output logic [LEN_W-1:0] x_tot_len_o,
  output logic             x_reads_open_o
);
  import sched_pkg::*;

  iter_t col_q;
  iter_t wcol_q;
  iter_t row_q;
  iter_t reads_q;
  addr_t col_offs_q;
  addr_t row_offs_q;

  logic  col_last;
  logic  wcol_last;
  logic  row_last;

  // Last index of each loop
  assign col_last  = (col_q == cfg.x_col_iters - iter_t'(1));
  assign wcol_last = (wcol_q == cfg.w_col_iters - iter_t'(1));
  assign row_last  = (row_q == cfg.x_row_iters - iter_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q      <= '0;
      wcol_q     <= '0;
      row_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear_i || sched_rst_i) begin
      col_q      <= '0;
      wcol_q     <= '0;
      row_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (x_done_i) begin
      if (col_last) begin
        col_q      <= '0;
        col_offs_q <= '0;
        wcol_q     <= wcol_last ? '0 : wcol_q + iter_t'(1);
        // Next row tile once every W column group has seen this one
        if (wcol_last) begin
          row_q      <= row_last ? '0 : row_q + iter_t'(1);
          row_offs_q <= row_last ? '0 : row_offs_q + x_rows_offs_i;
        end
      end else begin
        col_q      <= col_q + iter_t'(1);
        col_offs_q <= col_offs_q + addr_t'(COL_JUMP);
      end
    end
  end

  // X tiles fetched so far in this job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reads_q <= '0;
    end else if (clear_i || sched_rst_i) begin
      reads_q <= '0;
    end else if (x_done_i) begin
      reads_q <= reads_q + iter_t'(1);
    end
  end

  assign x_base_addr_o = x_addr_i + row_offs_q + col_offs_q;

  // Last row tile may hold fewer rows than the array width
  assign x_tot_len_o = (row_last && cfg.x_leftover != '0) ? LEN_W'(cfg.x_leftover)
                                                          : LEN_W'(ARRAY_W);

  assign x_reads_open_o = (reads_q != '0) && (reads_q != cfg.tot_x_reads);

endmodule : x_tile_walker

`default_nettype wire

// ==== hdl/job_desc_latch.sv ====
/*
  Job descriptor latch
  Captures the W and Z stream descriptors and the Y enable at job start
*/
`timescale 1ns/100ps
`default_nettype none

module job_desc_latch (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             sched_rst_i,
  loop_cfg_if.desc         cfg,
  input  sched_pkg::addr_t w_addr_i,
  input  sched_pkg::addr_t w_tot_len_i,
  input  sched_pkg::addr_t w_d0_stride_i,
  input  sched_pkg::addr_t z_addr_i,
  input  sched_pkg::addr_t z_tot_len_i,
  input  sched_pkg::addr_t z_d0_stride_i,
  input  sched_pkg::addr_t z_d2_stride_i,
  input  sched_pkg::iter_t w_row_iters_i,
  input  logic             y_enable_i,
  output sched_pkg::addr_t w_base_addr_o,
  output sched_pkg::addr_t w_tot_len_o,
  output sched_pkg::addr_t w_d0_stride_o,
  output sched_pkg::iter_t w_d0_len_o,
  output sched_pkg::iter_t w_d1_len_o,
  output sched_pkg::addr_t z_base_addr_o,
  output sched_pkg::addr_t z_tot_len_o,
  output sched_pkg::addr_t z_d0_stride_o,
  output sched_pkg::addr_t z_d2_stride_o,
  output sched_pkg::iter_t z_d1_len_o,
  output logic             y_en_q_o
);
  import sched_pkg::*;

  // W column groups, shared by the W d1 and Z d1 lengths
  iter_t col_groups_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_base_addr_o <= '0;
      w_tot_len_o   <= '0;
      w_d0_stride_o <= '0;
      w_d0_len_o    <= '0;
      z_base_addr_o <= '0;
      z_tot_len_o   <= '0;
      z_d0_stride_o <= '0;
      z_d2_stride_o <= '0;
      col_groups_q  <= '0;
      y_en_q_o      <= 1'b0;
    end else if (clear_i) begin
      w_base_addr_o <= '0;
      w_tot_len_o   <= '0;
      w_d0_stride_o <= '0;
      w_d0_len_o    <= '0;
      z_base_addr_o <= '0;
      z_tot_len_o   <= '0;
      z_d0_stride_o <= '0;
      z_d2_stride_o <= '0;
      col_groups_q  <= '0;
      y_en_q_o      <= 1'b0;
    end else if (sched_rst_i) begin
      w_base_addr_o <= w_addr_i;
      w_tot_len_o   <= w_tot_len_i;
      w_d0_stride_o <= w_d0_stride_i;
      w_d0_len_o    <= w_row_iters_i;
      z_base_addr_o <= z_addr_i;
      z_tot_len_o   <= z_tot_len_i;
      z_d0_stride_o <= z_d0_stride_i;
      z_d2_stride_o <= z_d2_stride_i;
      col_groups_q  <= cfg.w_col_iters;
      y_en_q_o      <= y_enable_i;
    end
  end

  assign w_d1_len_o = col_groups_q;
  assign z_d1_len_o = col_groups_q;

endmodule : job_desc_latch

`default_nettype wire

// ==== hdl/stream_start_ctrl.sv ====
/*
  Stream start controller
  Forms the X, W, Y and Z start requests from the load flags,
  the streamer ready levels and the walker status
*/
`timescale 1ns/100ps
`default_nettype none

module stream_start_ctrl (
  input  logic first_load_i,
  input  logic idle_i,
  input  logic x_reads_open_i,
  input  logic y_en_i,
  input  logic x_ready_i,
  input  logic w_ready_i,
  input  logic y_ready_i,
  input  logic z_ready_i,
  output logic x_req_start_o,
  output logic w_req_start_o,
  output logic y_req_start_o,
  output logic z_req_start_o
);

  logic x_want;

  // X keeps fetching tiles until the job's read count is used up
  assign x_want = first_load_i || x_reads_open_i;

  always_comb begin
    x_req_start_o = !idle_i && x_want && x_ready_i;

    // W, Y and Z only start on the first load of a job
    w_req_start_o = first_load_i && w_ready_i;
    y_req_start_o = first_load_i && y_en_i && y_ready_i;
    z_req_start_o = first_load_i && z_ready_i;
  end

endmodule : stream_start_ctrl

`default_nettype wire

// ==== hdl/mem_scheduler.sv ====
/*
  Memory scheduler
  Turns the job's loop bounds and addresses into X, W and Z stream
  descriptors and start requests for the matrix-multiply streamers
*/
`timescale 1ns/100ps
`default_nettype none

module mem_scheduler #(
  parameter  int unsigned ARRAY_W = 12,
  localparam int unsigned LEN_W   = $clog2(ARRAY_W) + 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             sched_rst_i,
  input  logic             first_load_i,
  input  logic             idle_i,
  input  logic             x_done_i,
  input  logic             x_ready_i,
  input  logic             w_ready_i,
  input  logic             y_ready_i,
  input  logic             z_ready_i,
  input  logic             y_enable_i,
  input  sched_pkg::addr_t x_addr_i,
  input  sched_pkg::addr_t x_rows_offs_i,
  input  sched_pkg::addr_t x_d1_stride_i,
  input  sched_pkg::addr_t w_addr_i,
  input  sched_pkg::addr_t w_tot_len_i,
  input  sched_pkg::addr_t w_d0_stride_i,
  input  sched_pkg::addr_t z_addr_i,
  input  sched_pkg::addr_t z_tot_len_i,
  input  sched_pkg::addr_t z_d0_stride_i,
  input  sched_pkg::addr_t z_d2_stride_i,
  input  sched_pkg::iter_t x_col_iters_i,
  input  sched_pkg::iter_t x_row_iters_i,
  input  sched_pkg::iter_t w_col_iters_i,
  input  sched_pkg::iter_t w_row_iters_i,
  input  sched_pkg::iter_t tot_x_reads_i,
  input  sched_pkg::len_t  x_leftover_i,
  output sched_pkg::addr_t x_base_addr_o,
  output sched_pkg::addr_t x_d1_stride_o,
  output sched_pkg::addr_t w_base_addr_o,
  output sched_pkg::addr_t w_tot_len_o,
  output sched_pkg::addr_t w_d0_stride_o,
  output sched_pkg::addr_t z_base_addr_o,
  output sched_pkg::addr_t z_tot_len_o,
  output sched_pkg::addr_t z_d0_stride_o,
  output sched_pkg::addr_t z_d2_stride_o,
  output sched_pkg::iter_t w_d0_len_o,
  output sched_pkg::iter_t w_d1_len_o,
  output sched_pkg::iter_t z_d1_len_o,
  output logic [LEN_W-1:0] x_tot_len_o,
  output logic             x_req_start_o,
  output logic             w_req_start_o,
  output logic             y_req_start_o,
  output logic             z_req_start_o
);

  logic x_reads_open;
  logic y_en_q;

  loop_cfg_if cfg ();

  assign cfg.x_col_iters = x_col_iters_i;
  assign cfg.x_row_iters = x_row_iters_i;
  assign cfg.w_col_iters = w_col_iters_i;
  assign cfg.tot_x_reads = tot_x_reads_i;
  assign cfg.x_leftover  = x_leftover_i;

  // X row stride is taken straight from the register file
  assign x_d1_stride_o = x_d1_stride_i;

  x_tile_walker #(
    .ARRAY_W (ARRAY_W),
    .LEN_W   (LEN_W)
  ) u_x_tile_walker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .sched_rst_i    (sched_rst_i),
    .x_done_i       (x_done_i),
    .cfg            (cfg.walker),
    .x_addr_i       (x_addr_i),
    .x_rows_offs_i  (x_rows_offs_i),
    .x_base_addr_o  (x_base_addr_o),
    .x_tot_len_o    (x_tot_len_o),
    .x_reads_open_o (x_reads_open)
  );

  job_desc_latch u_job_desc_latch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .sched_rst_i   (sched_rst_i),
    .cfg           (cfg.desc),
    .w_addr_i      (w_addr_i),
    .w_tot_len_i   (w_tot_len_i),
    .w_d0_stride_i (w_d0_stride_i),
    .z_addr_i      (z_addr_i),
    .z_tot_len_i   (z_tot_len_i),
    .z_d0_stride_i (z_d0_stride_i),
    .z_d2_stride_i (z_d2_stride_i),
    .w_row_iters_i (w_row_iters_i),
    .y_enable_i    (y_enable_i),
    .w_base_addr_o (w_base_addr_o),
    .w_tot_len_o   (w_tot_len_o),
    .w_d0_stride_o (w_d0_stride_o),
    .w_d0_len_o    (w_d0_len_o),
    .w_d1_len_o    (w_d1_len_o),
    .z_base_addr_o (z_base_addr_o),
    .z_tot_len_o   (z_tot_len_o),
    .z_d0_stride_o (z_d0_stride_o),
    .z_d2_stride_o (z_d2_stride_o),
    .z_d1_len_o    (z_d1_len_o),
    .y_en_q_o      (y_en_q)
  );

  stream_start_ctrl u_stream_start_ctrl (
    .first_load_i   (first_load_i),
    .idle_i         (idle_i),
    .x_reads_open_i (x_reads_open),
    .y_en_i         (y_en_q),
    .x_ready_i      (x_ready_i),
    .w_ready_i      (w_ready_i),
    .y_ready_i      (y_ready_i),
    .z_ready_i      (z_ready_i),
    .x_req_start_o  (x_req_start_o),
    .w_req_start_o  (w_req_start_o),
    .y_req_start_o  (y_req_start_o),
    .z_req_start_o  (z_req_start_o)
  );

endmodule : mem_scheduler

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
/*
  Testbench clock and reset
  Free-running clock and an active-low reset held for a few cycles
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule : tb_clk_gen

`default_nettype wire

// ==== test/mem_scheduler_sva.sv ====
/*
  Memory scheduler assertions
  Checks the start request rules and the descriptor state after reset
*/
`timescale 1ns/100ps
`default_nettype none

module mem_scheduler_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             first_load_i,
  input logic             idle_i,
  input logic             x_ready_i,
  input logic             w_ready_i,
  input logic             y_ready_i,
  input logic             z_ready_i,
  input logic             x_reads_open_i,
  input logic             y_en_q_i,
  input sched_pkg::addr_t w_base_addr_i,
  input sched_pkg::addr_t z_base_addr_i,
  input logic             x_req_start_i,
  input logic             w_req_start_i,
  input logic             y_req_start_i,
  input logic             z_req_start_i
);

  // Read by the testbench for its summary
  int unsigned fail_cnt = 0;

  x_req_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_req_start_i == (!idle_i && x_ready_i && (first_load_i || x_reads_open_i)))
    else begin
      $error("X start request does not follow idle, ready and load state");
      fail_cnt++;
    end

  w_req_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_req_start_i == (first_load_i && w_ready_i))
    else begin
      $error("W start request does not follow first load and W ready");
      fail_cnt++;
    end

  // Y also waits for the enable latched at job start
  y_req_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    y_req_start_i == (first_load_i && y_en_q_i && y_ready_i))
    else begin
      $error("Y start request does not follow first load, enable and Y ready");
      fail_cnt++;
    end

  z_req_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_req_start_i == (first_load_i && z_ready_i))
    else begin
      $error("Z start request does not follow first load and Z ready");
      fail_cnt++;
    end

  reset_state: assert property (@(posedge clk_i)
    !rst_ni |=> (w_base_addr_i == '0 && z_base_addr_i == '0 && !y_en_q_i && !x_reads_open_i))
    else begin
      $error("Descriptor state is not cleared by reset");
      fail_cnt++;
    end

endmodule : mem_scheduler_sva

bind mem_scheduler mem_scheduler_sva u_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .first_load_i   (first_load_i),
  .idle_i         (idle_i),
  .x_ready_i      (x_ready_i),
  .w_ready_i      (w_ready_i),
  .y_ready_i      (y_ready_i),
  .z_ready_i      (z_ready_i),
  .x_reads_open_i (x_reads_open),
  .y_en_q_i       (y_en_q),
  .w_base_addr_i  (w_base_addr_o),
  .z_base_addr_i  (z_base_addr_o),
  .x_req_start_i  (x_req_start_o),
  .w_req_start_i  (w_req_start_o),
  .y_req_start_i  (y_req_start_o),
  .z_req_start_i  (z_req_start_o)
);

`default_nettype wire

// ==== test/tb_mem_scheduler.sv ====
/*
  Memory scheduler testbench
  Walks X tiles, latches W/Z descriptors, sweeps the start request inputs
  and clears mid-walk, checking the outputs against a model of the rules
*/
`timescale 1ns/100ps
`default_nettype none

module tb_mem_scheduler;
  import sched_pkg::*;

  localparam int unsigned ARRAY_W  = 4;
  localparam int unsigned LEN_W    = $clog2(ARRAY_W) + 1;
  // One datapath word per X column tile
  localparam int unsigned COL_STEP = DATA_W / 8;

  logic clk_i;
  logic rst_ni;
  logic clear_i, sched_rst_i, first_load_i, idle_i, x_done_i, y_enable_i;
  logic x_ready_i, w_ready_i, y_ready_i, z_ready_i;
  addr_t x_addr_i, x_rows_offs_i, x_d1_stride_i, w_addr_i, w_tot_len_i, w_d0_stride_i;
  addr_t z_addr_i, z_tot_len_i, z_d0_stride_i, z_d2_stride_i;
  iter_t x_col_iters_i, x_row_iters_i, w_col_iters_i, w_row_iters_i, tot_x_reads_i;
  len_t  x_leftover_i;
  addr_t x_base_addr_o, x_d1_stride_o, w_base_addr_o, w_tot_len_o, w_d0_stride_o;
  addr_t z_base_addr_o, z_tot_len_o, z_d0_stride_o, z_d2_stride_o;
  iter_t w_d0_len_o, w_d1_len_o, z_d1_len_o;
  logic [LEN_W-1:0] x_tot_len_o;
  logic x_req_start_o, w_req_start_o, y_req_start_o, z_req_start_o;

  logic [15:0] lfsr_q = 16'd5218;
  addr_t exp_a [7];
  iter_t exp_rows, exp_cols;
  int    m_col, m_wcol, m_row, m_reads;
  int    err_cnt, test_start, tests_run, tests_failed;
  string test_name;
  logic  reset_ok;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  mem_scheduler #(.ARRAY_W(ARRAY_W)) u_dut (.*);

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(u_dut.u_sva.fail_cnt);
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error %s %s: expected %0h actual %0h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    test_start = total_errors();
  endtask

  task automatic end_test();
    tests_run++;
    if (total_errors() == test_start) begin
      $display("%s: pass", test_name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", test_name, total_errors() - test_start);
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic reset_model();
    m_col   = 0;
    m_wcol  = 0;
    m_row   = 0;
    m_reads = 0;
  endtask

  // Column, then W column group, then row
  task automatic advance_model();
    m_reads++;
    if (m_col < int'(x_col_iters_i) - 1) begin
      m_col++;
    end else begin
      m_col = 0;
      if (m_wcol < int'(w_col_iters_i) - 1) begin
        m_wcol++;
      end else begin
        m_wcol = 0;
        m_row  = (m_row < int'(x_row_iters_i) - 1) ? m_row + 1 : 0;
      end
    end
  endtask

  task automatic check_x();
    addr_t exp_base;
    int    exp_len;
    exp_base = x_addr_i + addr_t'(m_row) * x_rows_offs_i + addr_t'(m_col * COL_STEP);
    exp_len  = (m_row == int'(x_row_iters_i) - 1 && x_leftover_i != 0) ?
               int'(x_leftover_i) : ARRAY_W;
    check_val("x_base_addr", exp_base, x_base_addr_o);
    check_val("x_tot_len", exp_len, x_tot_len_o);
  endtask

  task automatic save_desc();
    exp_a    = '{w_addr_i, w_tot_len_i, w_d0_stride_i, z_addr_i, z_tot_len_i,
                 z_d0_stride_i, z_d2_stride_i};
    exp_rows = w_row_iters_i;
    exp_cols = w_col_iters_i;
  endtask

  task automatic check_desc();
    check_val("w_base_addr", exp_a[0], w_base_addr_o);
    check_val("w_tot_len", exp_a[1], w_tot_len_o);
    check_val("w_d0_stride", exp_a[2], w_d0_stride_o);
    check_val("z_base_addr", exp_a[3], z_base_addr_o);
    check_val("z_tot_len", exp_a[4], z_tot_len_o);
    check_val("z_d0_stride", exp_a[5], z_d0_stride_o);
    check_val("z_d2_stride", exp_a[6], z_d2_stride_o);
    check_val("w_d0_len", exp_rows, w_d0_len_o);
    check_val("w_d1_len", exp_cols, w_d1_len_o);
    check_val("z_d1_len", exp_cols, z_d1_len_o);
  endtask

  task automatic random_desc();
    w_addr_i      = rand_bits(32);
    w_tot_len_i   = rand_bits(32);
    w_d0_stride_i = rand_bits(32);
    z_addr_i      = rand_bits(32);
    z_tot_len_i   = rand_bits(32);
    z_d0_stride_i = rand_bits(32);
    z_d2_stride_i = rand_bits(32);
    x_d1_stride_i = rand_bits(32);
    w_row_iters_i = iter_t'(rand_bits(16));
    w_col_iters_i = iter_t'(rand_bits(3) + 1);
  endtask

  task automatic pulse_sched_rst();
    sched_rst_i = 1'b1;
    save_desc();
    reset_model();
    step();
    sched_rst_i = 1'b0;
  endtask

  task automatic pulse_done();
    x_done_i = 1'b1;
    advance_model();
    step();
    x_done_i = 1'b0;
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    step();
    clear_i = 1'b0;
  endtask

  task automatic set_loops(input int cols, input int wcols, input int rows, input int left);
    x_col_iters_i = iter_t'(cols);
    w_col_iters_i = iter_t'(wcols);
    x_row_iters_i = iter_t'(rows);
    x_leftover_i  = len_t'(left);
  endtask

  task automatic init_inputs();
    {clear_i, sched_rst_i, first_load_i, idle_i, x_done_i, y_enable_i} = '0;
    {x_ready_i, w_ready_i, y_ready_i, z_ready_i} = '0;
    {x_addr_i, x_rows_offs_i, x_d1_stride_i, w_addr_i, w_tot_len_i, w_d0_stride_i} = '0;
    {z_addr_i, z_tot_len_i, z_d0_stride_i, z_d2_stride_i} = '0;
    {x_col_iters_i, x_row_iters_i, w_col_iters_i, w_row_iters_i, tot_x_reads_i} = '0;
    x_leftover_i = '0;
  endtask

  task automatic wait_reset(output logic ok);
    int cycles;
    cycles = 0;
    while (!rst_ni && cycles < 20) begin
      @(posedge clk_i);
      cycles++;
    end
    #2;
    ok = rst_ni;
  endtask

  initial begin
    init_inputs();
    wait_reset(reset_ok);
    if (!reset_ok) begin
      $display("Timeout: reset was not released within 20 cycles");
    end else begin
      begin_test("x_walk");
      set_loops(3, 2, 2, 3);
      x_addr_i      = rand_bits(24) << 8;
      x_rows_offs_i = rand_bits(12) << 5;
      pulse_sched_rst();
      check_x();
      repeat (24) begin
        pulse_done();
        check_x();
      end
      end_test();

      // Zero leftover keeps full tiles on the last row
      begin_test("leftover");
      for (int left = 0; left < 4; left += 3) begin
        set_loops(3, 2, 3, left);
        pulse_sched_rst();
        check_x();
        repeat (18) begin
          pulse_done();
          check_x();
        end
      end
      end_test();

      begin_test("desc_latch");
      random_desc();
      {first_load_i, y_ready_i, y_enable_i} = 3'b111;
      pulse_sched_rst();
      check_desc();
      check_val("x_d1_stride", x_d1_stride_i, x_d1_stride_o);
      random_desc();
      y_enable_i = 1'b0;
      step();
      check_desc();
      check_val("y_req_start", 1, y_req_start_o);
      pulse_sched_rst();
      check_desc();
      check_val("y_req_start", 0, y_req_start_o);
      end_test();

      begin_test("start_req");
      set_loops(3, 2, 2, 0);
      tot_x_reads_i = 16'd100;
      for (int v = 0; v < 128; v++) begin
        {first_load_i, idle_i, y_enable_i, x_ready_i, w_ready_i, y_ready_i, z_ready_i} = 7'(v);
        pulse_sched_rst();
        pulse_done();
        step();
      end
      end_test();

      begin_test("x_continue");
      {first_load_i, idle_i, x_ready_i} = 3'b001;
      tot_x_reads_i = 16'd5;
      pulse_sched_rst();
      check_val("x_req_start", 0, x_req_start_o);
      for (int k = 0; k < int'(tot_x_reads_i); k++) begin
        pulse_done();
        check_val("x_req_start", m_reads != int'(tot_x_reads_i), x_req_start_o);
        x_ready_i = 1'b0;
        step();
        check_val("x_req_start", 0, x_req_start_o);
        x_ready_i = 1'b1;
      end
      repeat (3) begin
        step();
        check_val("x_req_start", 0, x_req_start_o);
      end
      end_test();

      begin_test("clear");
      random_desc();
      set_loops(3, 2, 2, 1);
      pulse_sched_rst();
      repeat (4) pulse_done();
      pulse_clear();
      exp_a    = '{default: '0};
      exp_rows = '0;
      exp_cols = '0;
      reset_model();
      check_x();
      check_desc();
      end_test();
    end

    $display("Summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, total_errors());
    if (reset_ok && tests_failed == 0 && total_errors() == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_mem_scheduler

`default_nettype wire

// ==== list.f ====
hdl/sched_pkg.sv
hdl/loop_cfg_if.sv
hdl/x_tile_walker.sv
hdl/job_desc_latch.sv
hdl/stream_start_ctrl.sv
hdl/mem_scheduler.sv
test/tb_clk_gen.sv
test/mem_scheduler_sva.sv
test/tb_mem_scheduler.sv

// ==== Makefile ====
TOP := tb_mem_scheduler

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only -Wall --timing --assert -f list.f --top-module mem_scheduler

clean:
	rm -rf obj_dir
